// File: rtl/retire_defines.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pipe latencies, reorder queue length and machine sizes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef RETIRE_DEFINES_SVH
`define RETIRE_DEFINES_SVH

// Cycles from dispatch to writeback of each pipe
`define INT_LATENCY 1
`define MEM_LATENCY 2
`define MUL_LATENCY 4

// One reorder slot per cycle of the slowest pipe
`define TRACE_QUEUE_LEN 4

`define NUM_THREADS 4
`define NUM_REGS 16
`define DMEM_WORDS 16

`endif

// File: rtl/core_types_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Machine word and index types, opcodes and pipe selection
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "retire_defines.svh"

package core_types_pkg;
	typedef logic [31:0] word_t;
	typedef logic [$clog2(`NUM_THREADS)-1:0] thread_idx_t;
	typedef logic [$clog2(`NUM_REGS)-1:0] reg_idx_t;

	typedef enum logic [2:0] {
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_XOR,
		OP_BEQZ,
		OP_LOAD,
		OP_STORE,
		OP_MUL
	} opcode_t;

	// Execution pipe that an instruction is dispatched to
	typedef enum logic [1:0] {
		PIPE_INT,
		PIPE_MEM,
		PIPE_MUL
	} pipe_sel_t;
endpackage

`default_nettype wire

// File: rtl/trace_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Kinds of retirement event carried by the trace port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package trace_pkg;
	// EV_NONE also marks an empty reorder slot
	typedef enum logic [1:0] {
		EV_NONE,
		EV_REG_WRITE,
		EV_STORE,
		EV_BRANCH
	} trace_kind_t;
endpackage

`default_nettype wire

// File: rtl/instruction_issue.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Issue unit with pending-write scoreboard, writeback port reservation
// and registered dispatch to the three pipes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "retire_defines.svh"

module instruction_issue(
	input wire clk,
	input wire reset,

	// Instruction source
	input wire instr_valid,
	input wire core_types_pkg::opcode_t instr_op,
	input wire core_types_pkg::thread_idx_t instr_thread,
	input wire core_types_pkg::reg_idx_t instr_dest,
	input wire core_types_pkg::reg_idx_t instr_src_a,
	input wire core_types_pkg::reg_idx_t instr_src_b,
	input wire core_types_pkg::word_t instr_imm,
	input wire core_types_pkg::word_t instr_pc,
	output logic issue_stall,

	// Register file read and writeback notification
	output core_types_pkg::thread_idx_t rf_read_thread,
	output core_types_pkg::reg_idx_t rf_read_a,
	output core_types_pkg::reg_idx_t rf_read_b,
	input wire core_types_pkg::word_t rf_value_a,
	input wire core_types_pkg::word_t rf_value_b,
	input wire wb_en,
	input wire core_types_pkg::thread_idx_t wb_thread,
	input wire core_types_pkg::reg_idx_t wb_reg,

	// Dispatch to the pipes
	output logic int_start,
	output logic mem_start,
	output logic mul_start,
	output core_types_pkg::opcode_t iss_op,
	output core_types_pkg::thread_idx_t iss_thread,
	output core_types_pkg::reg_idx_t iss_dest,
	output core_types_pkg::word_t iss_pc,
	output core_types_pkg::word_t iss_a,
	output core_types_pkg::word_t iss_b,
	output core_types_pkg::word_t iss_imm);

	import core_types_pkg::*;

	logic [`NUM_REGS-1:0] pending[`NUM_THREADS];
	// Bit i set means the writeback port is busy i + 1 cycles from now
	logic [`MUL_LATENCY-1:0] reserved;
	logic [`MUL_LATENCY-1:0] reserve_bit;
	pipe_sel_t pipe;
	logic uses_b;
	logic writes_dest;
	logic hazard;
	logic slot_busy;
	logic accept;
	word_t load_addr;

	assign rf_read_thread = instr_thread;
	assign rf_read_a = instr_src_a;
	assign rf_read_b = instr_src_b;
	assign load_addr = rf_value_a + instr_imm;

	always_comb
	begin
		reserve_bit = '0;
		case (instr_op)
			OP_LOAD, OP_STORE: pipe = PIPE_MEM;
			OP_MUL: pipe = PIPE_MUL;
			default: pipe = PIPE_INT;
		endcase

		uses_b = instr_op != OP_BEQZ && instr_op != OP_LOAD;

		// A load outside the scratch memory never writes back, so it claims no register
		writes_dest = !(instr_op inside {OP_BEQZ, OP_STORE})
			&& !(instr_op == OP_LOAD && load_addr >= `DMEM_WORDS);

		case (pipe)
			PIPE_MEM:
			begin
				slot_busy = reserved[`MEM_LATENCY];
				reserve_bit[`MEM_LATENCY-1] = 1'b1;
			end
			PIPE_MUL:
			begin
				// Nothing already in flight can finish as late as a new multiply
				slot_busy = 1'b0;
				reserve_bit[`MUL_LATENCY-1] = 1'b1;
			end
			default:
			begin
				slot_busy = reserved[`INT_LATENCY];
				reserve_bit[`INT_LATENCY-1] = 1'b1;
			end
		endcase

		hazard = pending[instr_thread][instr_src_a]
			|| (uses_b && pending[instr_thread][instr_src_b])
			|| (writes_dest && pending[instr_thread][instr_dest]);
	end

	assign issue_stall = instr_valid && (hazard || (writes_dest && slot_busy));
	assign accept = instr_valid && !issue_stall;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int t = 0; t < `NUM_THREADS; t++)
				pending[t] <= '0;
			reserved <= '0;
			int_start <= 1'b0;
			mem_start <= 1'b0;
			mul_start <= 1'b0;
		end
		else
		begin
			if (wb_en)
				pending[wb_thread][wb_reg] <= 1'b0;

			if (accept && writes_dest)
				pending[instr_thread][instr_dest] <= 1'b1;

			reserved <= (reserved >> 1) | ((accept && writes_dest) ? reserve_bit : '0);
			int_start <= accept && pipe == PIPE_INT;
			mem_start <= accept && pipe == PIPE_MEM;
			mul_start <= accept && pipe == PIPE_MUL;
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			iss_op <= instr_op;
			iss_thread <= instr_thread;
			iss_dest <= instr_dest;
			iss_pc <= instr_pc;
			iss_a <= rf_value_a;
			iss_b <= rf_value_b;
			iss_imm <= instr_imm;
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		$onehot0({int_start, mem_start, mul_start}));

	// Every register write from the pipes was booked here when it issued
	assert property (@(posedge clk) disable iff (reset)
		wb_en |-> $past(reserved[0]));
endmodule

`default_nettype wire

// File: rtl/int_pipe.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single-cycle integer ALU and branch resolution
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module int_pipe(
	input wire clk,
	input wire reset,
	input wire int_start,
	input wire core_types_pkg::opcode_t iss_op,
	input wire core_types_pkg::thread_idx_t iss_thread,
	input wire core_types_pkg::reg_idx_t iss_dest,
	input wire core_types_pkg::word_t iss_pc,
	input wire core_types_pkg::word_t iss_a,
	input wire core_types_pkg::word_t iss_b,
	input wire core_types_pkg::word_t iss_imm,
	output logic int_done,
	output core_types_pkg::thread_idx_t int_thread,
	output core_types_pkg::reg_idx_t int_dest,
	output core_types_pkg::word_t int_pc,
	output core_types_pkg::word_t int_result,
	output logic branch_taken,
	output core_types_pkg::word_t branch_target);

	import core_types_pkg::*;

	word_t alu_result;

	always_comb
	begin
		case (iss_op)
			OP_SUB: alu_result = iss_a - iss_b;
			OP_AND: alu_result = iss_a & iss_b;
			OP_XOR: alu_result = iss_a ^ iss_b;
			default: alu_result = iss_a + iss_b;
		endcase
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			int_done <= 1'b0;
			branch_taken <= 1'b0;
		end
		else
		begin
			// A branch never writes a register, taken or not
			int_done <= int_start && iss_op != OP_BEQZ;
			branch_taken <= int_start && iss_op == OP_BEQZ && iss_a == '0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (int_start)
		begin
			int_thread <= iss_thread;
			int_dest <= iss_dest;
			int_pc <= iss_pc;
			int_result <= alu_result;
			branch_target <= iss_pc + iss_imm;
		end
	end
endmodule

`default_nettype wire

// File: rtl/mul_pipe.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Four-stage pipelined 32-bit multiplier, low word of the product
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "retire_defines.svh"

module mul_pipe(
	input wire clk,
	input wire reset,
	input wire mul_start,
	input wire core_types_pkg::thread_idx_t iss_thread,
	input wire core_types_pkg::reg_idx_t iss_dest,
	input wire core_types_pkg::word_t iss_pc,
	input wire core_types_pkg::word_t iss_a,
	input wire core_types_pkg::word_t iss_b,
	output logic mul_done,
	output core_types_pkg::thread_idx_t mul_thread,
	output core_types_pkg::reg_idx_t mul_dest,
	output core_types_pkg::word_t mul_pc,
	output core_types_pkg::word_t mul_result);

	import core_types_pkg::*;

	logic [`MUL_LATENCY-1:0] valid_q;
	thread_idx_t thread_q[`MUL_LATENCY];
	reg_idx_t dest_q[`MUL_LATENCY];
	word_t pc_q[`MUL_LATENCY];

	// Only the low halves of the cross products reach bits 31:0
	word_t pp_low;
	logic [15:0] pp_cross_ab;
	logic [15:0] pp_cross_ba;
	word_t sum_q;
	word_t delay_q;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			valid_q <= '0;
		else
			valid_q <= {valid_q[`MUL_LATENCY-2:0], mul_start};
	end

	always_ff @(posedge clk)
	begin
		thread_q[0] <= iss_thread;
		dest_q[0] <= iss_dest;
		pc_q[0] <= iss_pc;
		for (int i = 1; i < `MUL_LATENCY; i++)
		begin
			thread_q[i] <= thread_q[i-1];
			dest_q[i] <= dest_q[i-1];
			pc_q[i] <= pc_q[i-1];
		end

		pp_low <= iss_a[15:0] * iss_b[15:0];
		pp_cross_ab <= iss_a[15:0] * iss_b[31:16];
		pp_cross_ba <= iss_a[31:16] * iss_b[15:0];
		sum_q <= pp_low + {pp_cross_ab + pp_cross_ba, 16'b0};
		delay_q <= sum_q;
		mul_result <= delay_q;
	end

	assign mul_done = valid_q[`MUL_LATENCY-1];
	assign mul_thread = thread_q[`MUL_LATENCY-1];
	assign mul_dest = dest_q[`MUL_LATENCY-1];
	assign mul_pc = pc_q[`MUL_LATENCY-1];
endmodule

`default_nettype wire

// File: rtl/mem_pipe.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-stage load/store pipe with the 16-word scratch memory
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "retire_defines.svh"

module mem_pipe(
	input wire clk,
	input wire reset,
	input wire mem_start,
	input wire core_types_pkg::opcode_t iss_op,
	input wire core_types_pkg::thread_idx_t iss_thread,
	input wire core_types_pkg::reg_idx_t iss_dest,
	input wire core_types_pkg::word_t iss_pc,
	input wire core_types_pkg::word_t iss_a,
	input wire core_types_pkg::word_t iss_b,
	input wire core_types_pkg::word_t iss_imm,
	output logic mem_done,
	output core_types_pkg::thread_idx_t mem_thread,
	output core_types_pkg::reg_idx_t mem_dest,
	output core_types_pkg::word_t mem_pc,
	output core_types_pkg::word_t mem_result,
	output logic store_done,
	output core_types_pkg::word_t store_addr,
	output core_types_pkg::word_t store_data);

	import core_types_pkg::*;

	localparam int ADDR_BITS = $clog2(`DMEM_WORDS);

	word_t mem[`DMEM_WORDS];
	word_t addr;
	logic in_range;
	logic s1_load;
	logic s1_store;
	logic [ADDR_BITS-1:0] s1_addr;
	word_t s1_data;
	thread_idx_t s1_thread;
	reg_idx_t s1_dest;
	word_t s1_pc;

	// Stage 1 forms the word address and drops anything past the memory
	assign addr = iss_a + iss_imm;
	assign in_range = addr < `DMEM_WORDS;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			s1_load <= 1'b0;
			s1_store <= 1'b0;
			mem_done <= 1'b0;
			store_done <= 1'b0;
			for (int i = 0; i < `DMEM_WORDS; i++)
				mem[i] <= '0;
		end
		else
		begin
			s1_load <= mem_start && iss_op == OP_LOAD && in_range;
			s1_store <= mem_start && iss_op == OP_STORE && in_range;
			mem_done <= s1_load;
			store_done <= s1_store;
			if (s1_store)
				mem[s1_addr] <= s1_data;
		end
	end

	always_ff @(posedge clk)
	begin
		s1_addr <= addr[ADDR_BITS-1:0];
		s1_data <= iss_b;
		s1_thread <= iss_thread;
		s1_dest <= iss_dest;
		s1_pc <= iss_pc;

		// Stage 2
		mem_result <= mem[s1_addr];
		mem_thread <= s1_thread;
		mem_dest <= s1_dest;
		mem_pc <= s1_pc;
		store_addr <= word_t'(s1_addr);
		store_data <= s1_data;
	end
endmodule

`default_nettype wire

// File: rtl/writeback_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Writeback mux and the per-thread register file
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "retire_defines.svh"

module writeback_stage(
	input wire clk,
	input wire reset,
	input wire int_done,
	input wire core_types_pkg::thread_idx_t int_thread,
	input wire core_types_pkg::reg_idx_t int_dest,
	input wire core_types_pkg::word_t int_pc,
	input wire core_types_pkg::word_t int_result,
	input wire mem_done,
	input wire core_types_pkg::thread_idx_t mem_thread,
	input wire core_types_pkg::reg_idx_t mem_dest,
	input wire core_types_pkg::word_t mem_pc,
	input wire core_types_pkg::word_t mem_result,
	input wire mul_done,
	input wire core_types_pkg::thread_idx_t mul_thread,
	input wire core_types_pkg::reg_idx_t mul_dest,
	input wire core_types_pkg::word_t mul_pc,
	input wire core_types_pkg::word_t mul_result,
	input wire core_types_pkg::thread_idx_t rf_read_thread,
	input wire core_types_pkg::reg_idx_t rf_read_a,
	input wire core_types_pkg::reg_idx_t rf_read_b,
	output core_types_pkg::word_t rf_value_a,
	output core_types_pkg::word_t rf_value_b,
	output logic wb_en,
	output core_types_pkg::pipe_sel_t wb_pipe,
	output core_types_pkg::thread_idx_t wb_thread,
	output core_types_pkg::reg_idx_t wb_reg,
	output core_types_pkg::word_t wb_value,
	output core_types_pkg::word_t wb_pc);

	import core_types_pkg::*;

	word_t regs[`NUM_THREADS][`NUM_REGS];

	assign rf_value_a = regs[rf_read_thread][rf_read_a];
	assign rf_value_b = regs[rf_read_thread][rf_read_b];

	// Issue reserves the port, so at most one pipe finishes in a cycle
	always_comb
	begin
		wb_en = int_done || mem_done || mul_done;
		wb_pipe = PIPE_INT;
		wb_thread = int_thread;
		wb_reg = int_dest;
		wb_value = int_result;
		wb_pc = int_pc;
		if (mem_done)
		begin
			wb_pipe = PIPE_MEM;
			wb_thread = mem_thread;
			wb_reg = mem_dest;
			wb_value = mem_result;
			wb_pc = mem_pc;
		end
		else if (mul_done)
		begin
			wb_pipe = PIPE_MUL;
			wb_thread = mul_thread;
			wb_reg = mul_dest;
			wb_value = mul_result;
			wb_pc = mul_pc;
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int t = 0; t < `NUM_THREADS; t++)
				for (int r = 0; r < `NUM_REGS; r++)
					regs[t][r] <= '0;
		end
		else if (wb_en)
			regs[wb_thread][wb_reg] <= wb_value;
	end

	assert property (@(posedge clk) disable iff (reset)
		$onehot0({int_done, mem_done, mul_done}));
endmodule

`default_nettype wire

// File: rtl/trace_reorder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reorder queue that puts retirement events back into issue order
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "retire_defines.svh"

module trace_reorder(
	input wire clk,
	input wire reset,

	// Register writes
	input wire wb_en,
	input wire core_types_pkg::pipe_sel_t wb_pipe,
	input wire core_types_pkg::thread_idx_t wb_thread,
	input wire core_types_pkg::reg_idx_t wb_reg,
	input wire core_types_pkg::word_t wb_value,
	input wire core_types_pkg::word_t wb_pc,

	// Taken branches and stores
	input wire branch_taken,
	input wire core_types_pkg::thread_idx_t int_thread,
	input wire core_types_pkg::word_t int_pc,
	input wire core_types_pkg::word_t branch_target,
	input wire store_done,
	input wire core_types_pkg::thread_idx_t mem_thread,
	input wire core_types_pkg::word_t mem_pc,
	input wire core_types_pkg::word_t store_addr,
	input wire core_types_pkg::word_t store_data,

	output logic trace_valid,
	output trace_pkg::trace_kind_t trace_kind,
	output core_types_pkg::thread_idx_t trace_thread,
	output core_types_pkg::word_t trace_pc,
	output core_types_pkg::reg_idx_t trace_reg,
	output core_types_pkg::word_t trace_addr,
	output core_types_pkg::word_t trace_data);

	import core_types_pkg::*;
	import trace_pkg::*;

	typedef struct packed {
		trace_kind_t kind;
		thread_idx_t thread;
		word_t pc;
		reg_idx_t regnum;
		word_t addr;
		word_t data;
	} trace_event_t;

	// A pipe of latency L reports L cycles late, so it enters that many slots further back
	localparam int STORE_SLOT = `TRACE_QUEUE_LEN - `MEM_LATENCY;
	localparam int BRANCH_SLOT = `TRACE_QUEUE_LEN - `INT_LATENCY;

	trace_event_t queue[`TRACE_QUEUE_LEN];
	trace_event_t wb_event;
	trace_event_t store_event;
	trace_event_t branch_event;
	int wb_slot;

	always_comb
	begin
		case (wb_pipe)
			PIPE_MEM: wb_slot = `TRACE_QUEUE_LEN - `MEM_LATENCY;
			PIPE_MUL: wb_slot = `TRACE_QUEUE_LEN - `MUL_LATENCY;
			default: wb_slot = `TRACE_QUEUE_LEN - `INT_LATENCY;
		endcase

		wb_event = '{kind: EV_REG_WRITE, thread: wb_thread, pc: wb_pc,
			regnum: wb_reg, addr: '0, data: wb_value};
		store_event = '{kind: EV_STORE, thread: mem_thread, pc: mem_pc,
			regnum: '0, addr: store_addr, data: store_data};
		branch_event = '{kind: EV_BRANCH, thread: int_thread, pc: int_pc,
			regnum: '0, addr: '0, data: branch_target};
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < `TRACE_QUEUE_LEN; i++)
				queue[i] <= '0;
		end
		else
		begin
			for (int i = 0; i < `TRACE_QUEUE_LEN - 1; i++)
				queue[i] <= queue[i + 1];
			queue[`TRACE_QUEUE_LEN - 1] <= '0;

			if (wb_en)
				queue[wb_slot] <= wb_event;
			if (store_done)
				queue[STORE_SLOT] <= store_event;
			if (branch_taken)
				queue[BRANCH_SLOT] <= branch_event;
		end
	end

	// Slot 0 drives the trace port directly
	assign trace_valid = queue[0].kind != EV_NONE;
	assign trace_kind = queue[0].kind;
	assign trace_thread = queue[0].thread;
	assign trace_pc = queue[0].pc;
	assign trace_reg = queue[0].regnum;
	assign trace_addr = queue[0].addr;
	assign trace_data = queue[0].data;

	// Instructions issued in different cycles never meet in one slot
	assert property (@(posedge clk) disable iff (reset)
		wb_en && wb_slot < `TRACE_QUEUE_LEN - 1 |-> queue[wb_slot + 1].kind == EV_NONE);
	assert property (@(posedge clk) disable iff (reset)
		store_done |-> queue[STORE_SLOT + 1].kind == EV_NONE);
	assert property (@(posedge clk) disable iff (reset)
		!(branch_taken && wb_en && wb_slot == BRANCH_SLOT));
endmodule

`default_nettype wire

// File: rtl/retire_trace_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core top level with issue, three pipes, writeback and retire tracer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module retire_trace_top(
	input wire clk,
	input wire reset,
	input wire instr_valid,
	input wire core_types_pkg::opcode_t instr_op,
	input wire core_types_pkg::thread_idx_t instr_thread,
	input wire core_types_pkg::reg_idx_t instr_dest,
	input wire core_types_pkg::reg_idx_t instr_src_a,
	input wire core_types_pkg::reg_idx_t instr_src_b,
	input wire core_types_pkg::word_t instr_imm,
	input wire core_types_pkg::word_t instr_pc,
	output logic issue_stall,
	output logic trace_valid,
	output trace_pkg::trace_kind_t trace_kind,
	output core_types_pkg::thread_idx_t trace_thread,
	output core_types_pkg::word_t trace_pc,
	output core_types_pkg::reg_idx_t trace_reg,
	output core_types_pkg::word_t trace_addr,
	output core_types_pkg::word_t trace_data);

	import core_types_pkg::*;

	// Net names match the block ports, so every instance connects by name
	thread_idx_t rf_read_thread;
	reg_idx_t rf_read_a;
	reg_idx_t rf_read_b;
	word_t rf_value_a;
	word_t rf_value_b;
	logic wb_en;
	pipe_sel_t wb_pipe;
	thread_idx_t wb_thread;
	reg_idx_t wb_reg;
	word_t wb_value;
	word_t wb_pc;

	logic int_start;
	logic mem_start;
	logic mul_start;
	opcode_t iss_op;
	thread_idx_t iss_thread;
	reg_idx_t iss_dest;
	word_t iss_pc;
	word_t iss_a;
	word_t iss_b;
	word_t iss_imm;

	logic int_done;
	thread_idx_t int_thread;
	reg_idx_t int_dest;
	word_t int_pc;
	word_t int_result;
	logic branch_taken;
	word_t branch_target;

	logic mem_done;
	thread_idx_t mem_thread;
	reg_idx_t mem_dest;
	word_t mem_pc;
	word_t mem_result;
	logic store_done;
	word_t store_addr;
	word_t store_data;

	logic mul_done;
	thread_idx_t mul_thread;
	reg_idx_t mul_dest;
	word_t mul_pc;
	word_t mul_result;

	instruction_issue i_issue(.*);
	int_pipe i_int_pipe(.*);
	mem_pipe i_mem_pipe(.*);
	mul_pipe i_mul_pipe(.*);
	writeback_stage i_writeback(.*);
	trace_reorder i_trace_reorder(.*);
endmodule

`default_nettype wire

// File: dv/tb_retire_trace.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the retire trace core driven from the tests file
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_retire_trace;
	import core_types_pkg::*;
	import trace_pkg::*;

	// Edges from accept to trace_valid through the dispatch register and the reorder slots
	localparam int TRACE_DELAY = 5;
	localparam int STALL_LIMIT = 40;
	localparam int DRAIN_LIMIT = 100;
	localparam int QUIET_CYCLES = 8;

	// One instruction and any trace event it should retire with
	typedef struct packed {
		logic [2:0] op;
		logic [1:0] thread;
		logic [3:0] dest;
		logic [3:0] src_a;
		logic [3:0] src_b;
		logic [31:0] imm;
		logic [31:0] pc;
		logic has_event;
		logic [1:0] kind;
		logic [1:0] ev_thread;
		logic [31:0] ev_pc;
		logic [3:0] ev_reg;
		logic [31:0] ev_addr;
		logic [31:0] ev_data;
	} test_rec_t;

	logic clk;
	logic reset;
	logic instr_valid;
	opcode_t instr_op;
	thread_idx_t instr_thread;
	reg_idx_t instr_dest;
	reg_idx_t instr_src_a;
	reg_idx_t instr_src_b;
	word_t instr_imm;
	word_t instr_pc;
	logic issue_stall;
	logic trace_valid;
	trace_kind_t trace_kind;
	thread_idx_t trace_thread;
	word_t trace_pc;
	reg_idx_t trace_reg;
	word_t trace_addr;
	word_t trace_data;

	test_rec_t program_q[$];
	test_rec_t expect_q[$];
	int due_cycle_q[$];
	int cycle_count = 0;
	int stall_cycles = 0;

	retire_trace_top i_dut(.*);

	initial
	begin
		clk = 1'b0;
		forever
			#10 clk = ~clk;
	end

	always @(posedge clk)
		cycle_count <= cycle_count + 1;

	task automatic stop_on_error();
		$display("Simulation finished: FAIL");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic check_field(input string name, input logic [31:0] got,
		input logic [31:0] want);
		assert (got == want)
		else
		begin
			$display("FAIL %s: got %h, expected %h", name, got, want);
			stop_on_error();
		end
	endtask

	task automatic load_tests();
		int fd;
		string line;
		logic [31:0] v[7];
		test_rec_t rec;
		logic have_rec;
		fd = $fopen("dv/retire_trace_tests.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the tests file dv/retire_trace_tests.txt");
			stop_on_error();
		end
		else
		begin
			have_rec = 1'b0;
			rec = '0;
			while ($fgets(line, fd) != 0)
			begin
				if ($sscanf(line, "I %h %h %h %h %h %h %h",
					v[0], v[1], v[2], v[3], v[4], v[5], v[6]) == 7)
				begin
					if (have_rec)
						program_q.push_back(rec);
					rec = '0;
					rec.op = v[0][2:0];
					rec.thread = v[1][1:0];
					rec.dest = v[2][3:0];
					rec.src_a = v[3][3:0];
					rec.src_b = v[4][3:0];
					rec.imm = v[5];
					rec.pc = v[6];
					have_rec = 1'b1;
				end
				else if ($sscanf(line, "E %h %h %h %h %h %h",
					v[0], v[1], v[2], v[3], v[4], v[5]) == 6)
				begin
					// An event line belongs to the instruction just above it
					rec.has_event = 1'b1;
					rec.kind = v[0][1:0];
					rec.ev_thread = v[1][1:0];
					rec.ev_pc = v[2];
					rec.ev_reg = v[3][3:0];
					rec.ev_addr = v[4];
					rec.ev_data = v[5];
				end
			end
			if (have_rec)
				program_q.push_back(rec);
			$fclose(fd);
		end
	endtask

	// Holds the instruction on the inputs until the edge that accepts it
	task automatic issue_instruction(input test_rec_t rec);
		int waited;
		int accept_cycle;
		instr_valid <= 1'b1;
		instr_op <= opcode_t'(rec.op);
		instr_thread <= rec.thread;
		instr_dest <= rec.dest;
		instr_src_a <= rec.src_a;
		instr_src_b <= rec.src_b;
		instr_imm <= rec.imm;
		instr_pc <= rec.pc;
		waited = 0;
		@(negedge clk);
		while (issue_stall)
		begin
			stall_cycles++;
			waited++;
			if (waited > STALL_LIMIT)
			begin
				$display("Instruction at pc %h stayed stalled for %0d cycles", rec.pc, waited);
				stop_on_error();
			end
			@(negedge clk);
		end
		accept_cycle = cycle_count + 1;
		@(posedge clk);
		if (rec.has_event)
		begin
			expect_q.push_back(rec);
			due_cycle_q.push_back(accept_cycle + TRACE_DELAY);
		end
	endtask

	task automatic check_trace_event();
		test_rec_t exp_rec;
		int due;
		if (expect_q.size() == 0)
		begin
			$display("A trace event appeared that no issued instruction should produce");
			stop_on_error();
		end
		else
		begin
			exp_rec = expect_q.pop_front();
			due = due_cycle_q.pop_front();
			check_field("trace_kind", trace_kind, exp_rec.kind);
			check_field("trace_thread", trace_thread, exp_rec.ev_thread);
			check_field("trace_pc", trace_pc, exp_rec.ev_pc);
			check_field("trace_reg", trace_reg, exp_rec.ev_reg);
			check_field("trace_addr", trace_addr, exp_rec.ev_addr);
			check_field("trace_data", trace_data, exp_rec.ev_data);
			check_field("trace_valid cycle", cycle_count, due);
		end
	endtask

	always @(negedge clk)
	begin
		if (!reset && trace_valid)
			check_trace_event();
	end

	initial
	begin
		int waited;
		reset = 1'b1;
		instr_valid = 1'b0;
		instr_op = OP_ADD;
		instr_thread = '0;
		instr_dest = '0;
		instr_src_a = '0;
		instr_src_b = '0;
		instr_imm = '0;
		instr_pc = '0;
		load_tests();
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		foreach (program_q[i])
			issue_instruction(program_q[i]);
		instr_valid <= 1'b0;

		waited = 0;
		while (expect_q.size() != 0)
		begin
			waited++;
			if (waited > DRAIN_LIMIT)
			begin
				$display("%0d expected trace events never appeared", expect_q.size());
				stop_on_error();
			end
			@(negedge clk);
		end
		// Any late extra event is caught by the monitor in this window
		repeat (QUIET_CYCLES) @(negedge clk);

		assert (stall_cycles > 0)
		else
		begin
			$display("Issue never stalled, although dependent instructions were sent");
			stop_on_error();
		end

		$display("Simulation finished: PASS");
		$finish;
	end
endmodule

`default_nettype wire

// File: dv/retire_trace_tests.txt
# I op thread dest src_a src_b imm pc (hex; op 0 add 1 sub 2 and 3 xor 4 beqz 5 load 6 store 7 mul)
# E kind thread pc reg addr data (hex; kind 1 reg write 2 store 3 branch), for the I line above
# ALU ops on all four threads, registers start at zero
I 0 0 1 2 3 0 100
E 1 0 100 1 0 0
I 1 1 2 4 5 0 104
E 1 1 104 2 0 0
I 3 2 3 1 2 0 108
E 1 2 108 3 0 0
I 2 3 4 5 6 0 10c
E 1 3 10c 4 0 0
# Multiply retires ahead of the faster ALU ops behind it
I 7 0 5 1 2 0 110
E 1 0 110 5 0 0
I 0 1 6 7 8 0 114
E 1 1 114 6 0 0
I 3 2 7 8 9 0 118
E 1 2 118 7 0 0
# Store then load of word 5, then a load and a store past the memory
I 6 1 0 0 9 5 11c
E 2 1 11c 0 5 0
I 5 1 a 0 0 5 120
E 1 1 120 a 0 0
I 5 1 b 0 0 14 124
I 6 2 0 0 1 30 128
# Branch on a zero register goes to pc + imm
I 4 3 0 1 0 40 12c
E 3 3 12c 0 0 16c
# Dependent chain on thread 0
I 0 0 c 1 2 0 130
E 1 0 130 c 0 0
I 1 0 d c 5 0 134
E 1 0 134 d 0 0
I 7 0 e d d 0 138
E 1 0 138 e 0 0
I 0 0 f e e 0 13c
E 1 0 13c f 0 0
I 5 0 1 f 0 5 140
E 1 0 140 1 0 0
I 0 0 2 1 1 0 144
E 1 0 144 2 0 0

// File: retire_trace_top.f
+incdir+rtl
rtl/core_types_pkg.sv
rtl/trace_pkg.sv
rtl/instruction_issue.sv
rtl/int_pipe.sv
rtl/mul_pipe.sv
rtl/mem_pipe.sv
rtl/writeback_stage.sv
rtl/trace_reorder.sv
rtl/retire_trace_top.sv
dv/tb_retire_trace.sv
